//--- gem_rx_pkg.sv
package gem_rx_pkg;

  // ----------------------------------------------------------
  // Link word and frame types
  // ----------------------------------------------------------
  typedef logic [15:0] fiber_word_t; // Two bytes per fiber word
  typedef logic [1:0]  k_flags_t;    // One K flag per byte, bit 0 = low byte
  typedef logic [55:0] frame_t;      // 7 payload bytes, byte 0 in bits 7:0
  typedef logic [7:0]  link_cnt_t;   // Link error count, saturating
  typedef logic [15:0] err_cnt_t;    // Error count as read by software
  typedef logic [3:0]  dly_sel_t;    // Crossing delay select, 0 means 1 bx

  // ----------------------------------------------------------
  // 8b/10b control characters
  // ----------------------------------------------------------
  localparam logic [7:0] k_comma = 8'hBC; // K28.5, frame marker
  localparam logic [7:0] k_start = 8'h3C; // K28.1, start pattern
  localparam logic [7:0] k_fc    = 8'hFC; // K28.7, latency code

  // Expected next PRBS frame
  // 56-bit Fibonacci LFSR, taps 56 55 35 34, stepped once per frame
  function automatic frame_t prbs_next(input frame_t prev);
    logic fb;
    fb = prev[55] ^ prev[54] ^ prev[34] ^ prev[33]; // Tap n is bit n-1
    return {prev[54:0], fb};
  endfunction

endpackage

//--- gem_frame_aligner.sv
`timescale 1ns/100ps
module gem_frame_aligner import gem_rx_pkg::*; #(
  parameter int LOCK_FRAMES = 4                   // Good frame markers needed to lock
) (
  input  logic        clock,
  input  logic        gtx_rx_reset,
  input  fiber_word_t rx_word,                    // One fiber word per clock
  input  k_flags_t    rx_k,                       // Per-byte K flags
  output logic        frame_strobe,               // One pulse per assembled frame
  output frame_t      frame_data,
  output logic        frame_k_err,                // Bad K usage somewhere in this frame
  output logic        rx_start,                   // Start pattern seen in word 0
  output logic        rx_fc,                      // Latency code seen in word 0
  output logic [7:0]  k_char,                     // Low byte of word 0, held
  output logic        aligned
);

  localparam int CNT_W = $clog2(LOCK_FRAMES + 1);

  typedef enum logic [1:0] {st_hunt, st_verify, st_locked} align_state_t;

  align_state_t     state;
  logic [1:0]       phase;                        // Phase of the incoming word
  logic [CNT_W-1:0] lock_cnt;
  logic [39:0]      pay_acc;                      // Payload bytes 0 to 4
  logic [7:0]       k0_q;                         // Word 0 code byte
  logic             kerr_acc;
  logic             is_comma;
  logic             is_kcode;
  logic             word0;
  logic             word3;

  // ----------------------------------------------------------
  // Word classification
  // ----------------------------------------------------------
  assign is_comma = rx_k[0] && (rx_word[7:0] == k_comma);
  assign is_kcode = rx_k[0] && (rx_word[7:0] == k_comma || rx_word[7:0] == k_start ||
                                rx_word[7:0] == k_fc);

  // Hunt restarts the phase on any comma, otherwise phase free-runs
  assign word0 = (state == st_hunt) ? is_comma : (phase == 2'd0);
  assign word3 = (state != st_hunt) && (phase == 2'd3);

  assign aligned = (state == st_locked);

  // ----------------------------------------------------------
  // Lock FSM and word phase
  // ----------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      state    <= st_hunt;
      phase    <= 2'd0;
      lock_cnt <= '0;
    end else begin
      case (state)
        st_hunt: begin
          if (is_comma) begin
            state    <= (LOCK_FRAMES <= 1) ? st_locked : st_verify;
            lock_cnt <= CNT_W'(1);
            phase    <= 2'd1;                     // Next word is word 1
          end
        end
        default: begin
          phase <= phase + 2'd1;
          if (phase == 2'd0) begin
            if (!is_kcode) begin
              state <= st_hunt;                   // Marker missing at expected phase
            end else if (state == st_verify) begin
              if (lock_cnt == CNT_W'(LOCK_FRAMES - 1)) state <= st_locked;
              else lock_cnt <= lock_cnt + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Payload collection, byte 0 rides in the high byte of word 0
  always_ff @(posedge clock) begin
    if (word0) begin
      pay_acc[7:0] <= rx_word[15:8];
      k0_q         <= rx_word[7:0];
    end
    if (state != st_hunt && phase == 2'd1) pay_acc[23:8]  <= rx_word;
    if (state != st_hunt && phase == 2'd2) pay_acc[39:24] <= rx_word;
    if (word3) frame_data <= {rx_word, pay_acc};  // Bytes 5 and 6 straight in
  end

  // ----------------------------------------------------------
  // Frame strobe, K errors and word 0 decode
  // ----------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      kerr_acc     <= 1'b0;
      frame_strobe <= 1'b0;
      frame_k_err  <= 1'b0;
      rx_start     <= 1'b0;
      rx_fc        <= 1'b0;
      k_char       <= 8'h00;
    end else begin
      frame_strobe <= word3;
      rx_start     <= word3 && (k0_q == k_start);
      rx_fc        <= word3 && (k0_q == k_fc);
      if (word0) kerr_acc <= rx_k[1] || !is_kcode; // K flag on payload byte 0
      else       kerr_acc <= kerr_acc || (|rx_k);
      if (word3) begin
        frame_k_err <= kerr_acc || (|rx_k);
        k_char      <= k0_q;
      end
    end
  end

endmodule

//--- gem_link_monitor.sv
`timescale 1ns/100ps
module gem_link_monitor import gem_rx_pkg::*; #(
  parameter int LOCK_FRAMES = 4                   // Clean frames in a row for link good
) (
  input  logic      clock,
  input  logic      gtx_rx_reset,
  input  logic      ttc_resync,                   // Clears all link status
  input  logic      frame_strobe,
  input  logic      frame_k_err,
  input  logic      aligned,
  output logic      link_good,
  output logic      link_bad,
  output logic      link_had_err,                 // Sticky until resync
  output link_cnt_t link_errcount
);

  localparam int CNT_W = $clog2(LOCK_FRAMES + 1);

  logic [CNT_W-1:0] good_run;                     // Clean frames since last error
  logic             aligned_q;
  logic             lost_align;
  logic             link_err;
  logic             clean_frame;

  // ----------------------------------------------------------
  // Error events
  // ----------------------------------------------------------
  assign lost_align  = aligned_q && !aligned;     // Falling edge of aligned
  assign link_err    = (frame_strobe && frame_k_err) || lost_align;
  assign clean_frame = frame_strobe && !frame_k_err;

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      aligned_q     <= 1'b0;
      good_run      <= '0;
      link_good     <= 1'b0;
      link_bad      <= 1'b0;
      link_had_err  <= 1'b0;
      link_errcount <= '0;
    end else if (ttc_resync) begin
      aligned_q     <= aligned;                   // Keep edge detect honest across resync
      good_run      <= '0;
      link_good     <= 1'b0;
      link_bad      <= 1'b0;
      link_had_err  <= 1'b0;
      link_errcount <= '0;
    end else begin
      aligned_q <= aligned;
      if (link_err) begin
        good_run     <= '0;
        link_good    <= 1'b0;                     // Drop good until a fresh clean run
        link_had_err <= 1'b1;
        if (link_errcount != 8'hFF) link_errcount <= link_errcount + 1'b1;
        if (link_errcount >= 8'hFE) link_bad <= 1'b1; // Count hits 255 here
      end else if (clean_frame) begin
        if (good_run != CNT_W'(LOCK_FRAMES)) good_run <= good_run + 1'b1;
        if (good_run == CNT_W'(LOCK_FRAMES - 1)) link_good <= 1'b1;
      end
    end
  end

endmodule

//--- gem_prbs_checker.sv
`timescale 1ns/100ps
module gem_prbs_checker import gem_rx_pkg::*; (
  input  logic     clock,
  input  logic     gtx_rx_reset,
  input  logic     prbs_en,                       // PRBS test mode
  input  logic     frame_strobe,
  input  frame_t   frame_data,
  input  logic     aligned,
  output logic     rx_match,                      // Frame followed the PRBS sequence
  output logic     prbs_err,
  output err_cnt_t prbs_errcount
);

  frame_t prev_frame;
  frame_t expect_frame;
  logic   prev_valid;                             // prev_frame holds a real frame
  logic   armed;                                  // First test frame already seen
  logic   match_now;

  // ----------------------------------------------------------
  // Prediction from the previous frame
  // ----------------------------------------------------------
  assign expect_frame = prbs_next(prev_frame);
  assign match_now    = prev_valid && (frame_data == expect_frame);

  // Self-synchronizing, always predict from what was received
  always_ff @(posedge clock) begin
    if (frame_strobe) prev_frame <= frame_data;
  end

  // ----------------------------------------------------------
  // Match flag and error counter
  // ----------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      prev_valid    <= 1'b0;
      armed         <= 1'b0;
      rx_match      <= 1'b0;
      prbs_err      <= 1'b0;
      prbs_errcount <= '0;
    end else begin
      if (frame_strobe) begin
        prev_valid <= 1'b1;
        rx_match   <= match_now;
      end
      if (!prbs_en) begin
        armed         <= 1'b0;                    // Test off, start over next time
        prbs_err      <= 1'b0;
        prbs_errcount <= '0;
      end else if (frame_strobe) begin
        armed <= 1'b1;
        if (aligned && armed && !match_now) begin
          prbs_err <= 1'b1;
          if (prbs_errcount != 16'hFFFF) prbs_errcount <= prbs_errcount + 1'b1;
        end else begin
          prbs_err <= 1'b0;
        end
      end
    end
  end

endmodule

//--- gem_bx_delay.sv
`timescale 1ns/100ps
module gem_bx_delay import gem_rx_pkg::*; (
  input  logic     clock,
  input  logic     gtx_rx_reset,
  input  logic     frame_strobe,                  // Advance once per crossing
  input  frame_t   frame_data,
  input  dly_sel_t delay_is,                      // 0 to 15 gives 1 to 16 bx
  input  logic     ignore_link,                   // Link not usable, feed zeros
  output frame_t   gtx_rx_data
);

  frame_t dly_line [16];

  // ----------------------------------------------------------
  // 16-deep frame shift register
  // ----------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      for (int i = 0; i < 16; i++) begin
        dly_line[i] <= '0;                        // Line reads zero until filled
      end
    end else if (frame_strobe) begin
      dly_line[0] <= ignore_link ? '0 : frame_data; // Keep bad links off the triads
      for (int i = 1; i < 16; i++) begin
        dly_line[i] <= dly_line[i-1];
      end
    end
  end

  // Tap read with pre-shift contents, so tap 0 is one crossing old
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) gtx_rx_data <= '0;
    else if (frame_strobe) gtx_rx_data <= dly_line[delay_is];
  end

endmodule

//--- gem_gtx_optical_rx.sv
`timescale 1ns/100ps
module gem_gtx_optical_rx import gem_rx_pkg::*; #(
  parameter int LOCK_FRAMES = 4                   // Frames to lock and to call link good
) (
  input  logic        clock,
  input  logic        gtx_rx_reset,
  input  logic        clear_sync,                 // Clears registered status
  input  logic        ttc_resync,                 // Clears link monitor
  input  fiber_word_t rx_word,
  input  k_flags_t    rx_k,
  input  logic        gtx_rx_en_prbs_test,        // PRBS test mode
  input  dly_sel_t    delay_is,
  output logic        gtx_rx_start,
  output logic        gtx_rx_fc,
  output logic        gtx_rx_valid,               // Aligned on commas
  output logic        gtx_rx_match,
  output logic        gtx_rx_sync_done,           // Link good
  output logic        gtx_rx_err,
  output err_cnt_t    gtx_rx_err_count,           // PRBS or link errors, by mode
  output frame_t      gtx_rx_data,
  output logic [7:0]  k_char,
  output logic        link_had_err,
  output logic        link_good,
  output logic        link_bad
);

  logic       frame_strobe;
  frame_t     frame_data;
  logic       frame_k_err;
  logic       rx_start, rx_fc;
  logic [7:0] rx_k_char;
  logic       aligned;
  logic       mon_good, mon_bad, mon_had_err;
  link_cnt_t  link_errcount;
  logic       rx_match, prbs_err;
  err_cnt_t   prbs_errcount;
  logic       ignore_link;

  // ----------------------------------------------------------
  // Receive blocks
  // ----------------------------------------------------------
  gem_frame_aligner #(.LOCK_FRAMES(LOCK_FRAMES)) i_aligner (
    .clock, .gtx_rx_reset, .rx_word, .rx_k,
    .frame_strobe, .frame_data, .frame_k_err,
    .rx_start, .rx_fc, .k_char(rx_k_char), .aligned
  );

  gem_link_monitor #(.LOCK_FRAMES(LOCK_FRAMES)) i_link_monitor (
    .clock, .gtx_rx_reset, .ttc_resync, .frame_strobe, .frame_k_err, .aligned,
    .link_good(mon_good), .link_bad(mon_bad), .link_had_err(mon_had_err), .link_errcount
  );

  gem_prbs_checker i_prbs_checker (
    .clock, .gtx_rx_reset, .prbs_en(gtx_rx_en_prbs_test), .frame_strobe, .frame_data,
    .aligned, .rx_match, .prbs_err, .prbs_errcount
  );

  assign ignore_link = !mon_good || mon_bad;      // Zero payload on an unusable link

  gem_bx_delay i_bx_delay (
    .clock, .gtx_rx_reset, .frame_strobe, .frame_data, .delay_is, .ignore_link,
    .gtx_rx_data
  );

  // ----------------------------------------------------------
  // Registered status outputs
  // ----------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      gtx_rx_start     <= 1'b0;
      gtx_rx_fc        <= 1'b0;
      gtx_rx_valid     <= 1'b0;
      gtx_rx_match     <= 1'b0;
      gtx_rx_sync_done <= 1'b0;
      gtx_rx_err       <= 1'b0;
      gtx_rx_err_count <= '0;
      k_char           <= 8'h00;
      link_had_err     <= 1'b0;
      link_good        <= 1'b0;
      link_bad         <= 1'b0;
    end else if (clear_sync) begin
      gtx_rx_start     <= 1'b0;
      gtx_rx_fc        <= 1'b0;
      gtx_rx_valid     <= 1'b0;
      gtx_rx_match     <= 1'b0;
      gtx_rx_sync_done <= 1'b0;
      gtx_rx_err       <= 1'b0;
      gtx_rx_err_count <= '0;
      k_char           <= 8'h00;
      link_had_err     <= 1'b0;
      link_good        <= 1'b0;
      link_bad         <= 1'b0;
    end else begin
      gtx_rx_start     <= rx_start;
      gtx_rx_fc        <= rx_fc;
      gtx_rx_valid     <= aligned;
      gtx_rx_match     <= rx_match;
      gtx_rx_sync_done <= mon_good;
      gtx_rx_err       <= prbs_err;
      gtx_rx_err_count <= gtx_rx_en_prbs_test ? prbs_errcount : {8'h00, link_errcount};
      k_char           <= rx_k_char;
      link_had_err     <= mon_had_err;
      link_good        <= mon_good;
      link_bad         <= mon_bad;
    end
  end

endmodule

//--- tb_gem_rx_stim.svh
`ifndef TB_GEM_RX_STIM_SVH
`define TB_GEM_RX_STIM_SVH

// ------------------------------------------------------------
// Reference model, advanced once per frame sent
// ------------------------------------------------------------
frame_t      ref_line [16];                     // Frames as the delay line should hold them
logic [65:0] exp_q [$];                         // {prbs err, match, code, data} per strobe
frame_t      prev_sent;
bit          have_prev;
bit          prev_en;                           // PRBS mode of the previous frame
int          clean_run;                         // Clean frames since last error or resync

// One frame: word 0 carries the code, kerr flags payload byte 4 as K
task automatic send_frame(input logic [7:0] code, input frame_t pay, input bit kerr);
  fiber_word_t w [4];
  logic        match;
  w = '{{pay[7:0], code}, pay[23:8], pay[39:24], pay[55:40]};
  if (req_resync) clean_run = 0;
  match = have_prev && (pay == lfsr_step(prev_sent));
  exp_q.push_back({req_prbs && prev_en && !match, match, code, ref_line[req_delay]});
  for (int i = 15; i > 0; i--) ref_line[i] = ref_line[i-1];
  ref_line[0] = (clean_run >= LOCK_FRAMES) ? pay : '0; // Link not good yet, zeros
  clean_run   = kerr ? 0 : clean_run + 1;
  prev_sent   = pay;
  have_prev   = 1'b1;
  prev_en     = req_prbs;
  for (int i = 0; i < 4; i++) begin
    @(posedge clock);
    rx_word <= w[i];
    rx_k    <= (i == 0) ? 2'b01 : {kerr && i == 2, 1'b0};
    sent_w3 <= (i == 3);
    if (i == 1) begin                             // Previous strobe has been sampled here
      delay_is            <= req_delay;
      gtx_rx_en_prbs_test <= req_prbs;
      ttc_resync          <= req_resync;
      clear_sync          <= req_clear;
    end
    if (i == 2) ttc_resync <= 1'b0;               // Single cycle resync
  end
  req_resync = 1'b0;
endtask

// Idle words, no commas, so the aligner drops out of lock
task automatic send_idle(input int cycles);
  repeat (cycles) begin
    @(posedge clock);
    rx_word <= '0;
    rx_k    <= '0;
    sent_w3 <= 1'b0;
  end
endtask

`endif

//--- tb_gem_gtx_optical_rx.sv
`timescale 1ns/100ps
module tb_gem_gtx_optical_rx import gem_rx_pkg::*; ();

  localparam int     LOCK_FRAMES  = 4;
  localparam int     DLY_FRAMES   = 20;           // Frames per delay setting
  localparam int     LINK_ERRS    = 3;
  localparam int     PRBS_FRAMES  = 14;
  localparam int     PRBS_BAD     = 2;            // Corrupted at index 3 and 7
  localparam frame_t PRBS_FLIP    = 56'h00_0080_0000_0001;
  localparam int     TOTAL_FRAMES = (LOCK_FRAMES + 1) + 4 * DLY_FRAMES + 6 +
                                    (LINK_ERRS + LOCK_FRAMES + 3) + (PRBS_FRAMES + 1) + 4;
  localparam int     TIMEOUT_CYC  = TOTAL_FRAMES * 4 + 200;

  logic        clock = 1'b0;
  logic        gtx_rx_reset, clear_sync, ttc_resync, gtx_rx_en_prbs_test;
  fiber_word_t rx_word;
  k_flags_t    rx_k;
  dly_sel_t    delay_is;
  logic        gtx_rx_start, gtx_rx_fc, gtx_rx_valid, gtx_rx_match, gtx_rx_sync_done;
  logic        gtx_rx_err, link_had_err, link_good, link_bad;
  err_cnt_t    gtx_rx_err_count;
  frame_t      gtx_rx_data;
  logic [7:0]  k_char;
  logic [32:0] status_bits;                       // Registered flags, count and code byte

  dly_sel_t    req_delay;                         // Controls applied at word 1
  bit          req_prbs, req_resync, req_clear;
  logic        sent_w3;
  logic        strobe_seen = 1'b0;
  logic        chk_now = 1'b0;
  logic        chk_late = 1'b0;
  logic        clr_q = 1'b0;
  logic [65:0] rec, late_rec;
  string       test_name = "reset";
  logic [31:0] lcg_state = 32'h2389_5981;
  dly_sel_t    dly_set [4] = '{4'd0, 4'd3, 4'd15, 4'd7};

  gem_gtx_optical_rx #(.LOCK_FRAMES(LOCK_FRAMES)) i_gem_gtx_optical_rx (.*);

  assign status_bits = {gtx_rx_start, gtx_rx_fc, gtx_rx_valid, gtx_rx_match, gtx_rx_sync_done,
                        gtx_rx_err, link_had_err, link_good, link_bad, gtx_rx_err_count, k_char};

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic frame_t rand_frame();
    logic [31:0] hi;
    lcg_state = lcg_next(lcg_state);
    hi        = lcg_state;
    lcg_state = lcg_next(lcg_state);
    return {hi[23:0], lcg_state};
  endfunction

  // Shift up one with feedback from taps 56 55 35 34 into bit 0
  function automatic frame_t lfsr_step(input frame_t s);
    frame_t n;
    n    = s << 1;
    n[0] = s[55] ^ s[54] ^ s[34] ^ s[33];
    return n;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    $display("** Error [%s] %s", test_name, msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  `include "tb_gem_rx_stim.svh"

  always #50 clock = ~clock;                      // 100 ns period

  // ----------------------------------------------------------
  // Strobe timing and per-frame checks
  // ----------------------------------------------------------
  always @(posedge clock) begin
    strobe_seen <= sent_w3;                       // Lines up with frame_strobe
    chk_now     <= strobe_seen;                   // Data and decodes settled
    chk_late    <= chk_now;                       // Match and err one cycle later
    clr_q       <= clear_sync;
  end

  always @(negedge clock) begin
    if (chk_now && exp_q.size() == 0) begin
      report_failure("frame strobe with nothing in the reference queue");
    end else if (chk_now) begin
      rec      = exp_q.pop_front();
      late_rec = rec;
      assert (gtx_rx_data == rec[55:0])
        else report_mismatch("gtx_rx_data", rec[55:0], gtx_rx_data);
      if (!clear_sync && !clr_q) begin            // Status is forced to zero around a clear
        assert (k_char == rec[63:56]) else report_mismatch("k_char", rec[63:56], k_char);
        assert (gtx_rx_start == (rec[63:56] == k_start))
          else report_mismatch("gtx_rx_start", rec[63:56] == k_start, gtx_rx_start);
        assert (gtx_rx_fc == (rec[63:56] == k_fc))
          else report_mismatch("gtx_rx_fc", rec[63:56] == k_fc, gtx_rx_fc);
      end
    end
    if (chk_late && !clear_sync && !clr_q) begin
      assert (gtx_rx_match == late_rec[64])
        else report_mismatch("gtx_rx_match", late_rec[64], gtx_rx_match);
      assert (gtx_rx_err == late_rec[65])
        else report_mismatch("gtx_rx_err", late_rec[65], gtx_rx_err);
    end
  end

  // Code pulses last one cycle
  assert property (@(posedge clock) disable iff (gtx_rx_reset)
                   (gtx_rx_start || gtx_rx_fc) |=> !(gtx_rx_start || gtx_rx_fc))
    else report_failure("start or FC pulse held for more than one cycle");

  initial begin                                   // Watchdog
    repeat (TIMEOUT_CYC) @(posedge clock);
    report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYC));
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin : main_seq
    frame_t pay;
    gtx_rx_reset = 1'b1;
    {clear_sync, ttc_resync, gtx_rx_en_prbs_test, sent_w3} = '0;
    rx_word  = '0;
    rx_k     = '0;
    delay_is = '0;
    {req_delay, req_prbs, req_resync, req_clear} = '0;
    {have_prev, prev_en, clean_run} = '0;
    foreach (ref_line[i]) ref_line[i] = '0;
    repeat (4) @(posedge clock);
    gtx_rx_reset <= 1'b0;
    @(negedge clock);
    assert (status_bits == '0) else report_mismatch("status after reset", 0, status_bits);
    assert (gtx_rx_data == '0) else report_mismatch("gtx_rx_data after reset", 0, gtx_rx_data);

    test_name = "lock";
    repeat (LOCK_FRAMES + 1) send_frame(k_comma, rand_frame(), 1'b0);
    @(negedge clock);
    assert ({gtx_rx_valid, link_good, gtx_rx_sync_done, link_bad} == 4'b1110)
      else report_mismatch("valid good sync_done bad", 4'b1110,
                           {gtx_rx_valid, link_good, gtx_rx_sync_done, link_bad});

    test_name = "delay_line";
    foreach (dly_set[j]) begin
      req_delay = dly_set[j];
      repeat (DLY_FRAMES) send_frame(k_comma, rand_frame(), 1'b0);
    end

    test_name = "code_decode";
    send_frame(k_start, rand_frame(), 1'b0);
    send_frame(k_comma, rand_frame(), 1'b0);
    send_frame(k_fc, rand_frame(), 1'b0);
    send_frame(k_fc, rand_frame(), 1'b0);
    send_frame(k_start, rand_frame(), 1'b0);
    send_frame(k_comma, rand_frame(), 1'b0);

    test_name = "link_errors";
    repeat (LINK_ERRS) send_frame(k_comma, rand_frame(), 1'b1);
    send_frame(k_comma, rand_frame(), 1'b0);
    @(negedge clock);
    assert (gtx_rx_err_count == LINK_ERRS)
      else report_mismatch("gtx_rx_err_count", LINK_ERRS, gtx_rx_err_count);
    assert ({link_had_err, link_good} == 2'b10)
      else report_mismatch("had_err good", 2'b10, {link_had_err, link_good});
    req_resync = 1'b1;
    send_frame(k_comma, rand_frame(), 1'b0);
    @(negedge clock);
    assert ({gtx_rx_err_count, link_had_err} == '0)
      else report_mismatch("count after resync", 0, {gtx_rx_err_count, link_had_err});
    repeat (LOCK_FRAMES + 1) send_frame(k_comma, rand_frame(), 1'b0);

    test_name = "prbs";
    req_prbs = 1'b1;
    pay      = rand_frame();
    for (int j = 0; j < PRBS_FRAMES; j++) begin
      send_frame(k_comma, (j == 3 || j == 7) ? pay ^ PRBS_FLIP : pay, 1'b0);
      pay = lfsr_step(pay);
    end
    @(negedge clock);
    assert (gtx_rx_err_count == 2 * PRBS_BAD)
      else report_mismatch("prbs count", 2 * PRBS_BAD, gtx_rx_err_count);
    req_prbs = 1'b0;
    send_frame(k_comma, pay, 1'b0);

    test_name = "clear_sync";
    req_clear = 1'b1;
    repeat (2) send_frame(k_start, rand_frame(), 1'b0);
    @(negedge clock);
    assert (status_bits == '0)
      else report_mismatch("status while clear_sync held", 0, status_bits);
    req_clear = 1'b0;
    repeat (2) send_frame(k_comma, rand_frame(), 1'b0);
    @(negedge clock);
    assert ({gtx_rx_valid, gtx_rx_sync_done} == 2'b11)
      else report_mismatch("valid sync_done", 2'b11, {gtx_rx_valid, gtx_rx_sync_done});

    test_name = "drain";
    send_idle(8);
    @(negedge clock);
    if (exp_q.size() != 0) begin
      report_failure("frames left unchecked in the reference queue");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

//--- filelist.f
+incdir+.
gem_rx_pkg.sv
gem_frame_aligner.sv
gem_link_monitor.sv
gem_prbs_checker.sv
gem_bx_delay.sv
gem_gtx_optical_rx.sv
tb_gem_gtx_optical_rx.sv
